// ==== ram_reader_pkg.sv ====
package ram_reader_pkg;

  localparam int AXI_ADDR_W  = 32;
  localparam int AXI_DATA_W  = 64;
  localparam int SAMPLE_W    = 32;
  localparam int SLOT_W      = 16;
  localparam int BURST_BEATS = 16;
  localparam int BEAT_BYTES  = 8;
  localparam int SLOT_SHIFT  = 7;  // BURST_BEATS * BEAT_BYTES bytes per slot.
  localparam int FIFO_DEPTH  = 64;
  localparam int FIFO_CNT_W  = 7;
  localparam int APB_ADDR_W  = 4;

  // ********************
  // Register map.
  localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 4'h0;
  localparam logic [APB_ADDR_W-1:0] REG_BASE   = 4'h4;
  localparam logic [APB_ADDR_W-1:0] REG_CFG    = 4'h8;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS = 4'hC;

  // Config word, seen as a limit or as quarter plus offset.
  typedef union packed {
    logic [SLOT_W-1:0] raw;
    struct packed {
      logic [1:0]        start_quarter;
      logic [SLOT_W-3:0] offset;
    } parts;
  } cfg_word_u;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [31:0]           pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic [AXI_ADDR_W-1:0] araddr;
  } axi_ar_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] rdata;
    logic                  rlast;
  } axi_r_t;

  typedef struct packed {
    logic                  enable;
    logic [AXI_ADDR_W-1:0] base;
    cfg_word_u             cfg;
  } reader_cfg_t;

endpackage

// ==== ram_reader_apb_regs.sv ====
`timescale 1ns/1ns

module ram_reader_apb_regs
(
  input  logic                                  aclk,
  input  logic                                  aresetn,
  input  ram_reader_pkg::apb_req_t              apb_req,
  output ram_reader_pkg::apb_rsp_t              apb_rsp,
  input  logic [ram_reader_pkg::SLOT_W-1:0]     slot_index,
  output ram_reader_pkg::reader_cfg_t           cfg
);

  logic access;
  logic wr_access;
  logic wr_mapped;

  assign access    = apb_req.psel & apb_req.penable;
  assign wr_access = access & apb_req.pwrite;
  assign wr_mapped = (apb_req.paddr == ram_reader_pkg::REG_CTRL) ||
                     (apb_req.paddr == ram_reader_pkg::REG_BASE) ||
                     (apb_req.paddr == ram_reader_pkg::REG_CFG);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      cfg.enable <= 1'b0;
      cfg.base   <= '0;
      cfg.cfg    <= '0;
    end
    else if (wr_access)
    begin
      case (apb_req.paddr)
        ram_reader_pkg::REG_CTRL: cfg.enable <= apb_req.pwdata[0];
        ram_reader_pkg::REG_BASE: cfg.base   <= apb_req.pwdata;
        ram_reader_pkg::REG_CFG:  cfg.cfg    <= apb_req.pwdata[ram_reader_pkg::SLOT_W-1:0];
        default: ;  // Status and holes are not writable.
      endcase
    end
  end

  // Read mux.
  always_comb
  begin
    case (apb_req.paddr)
      ram_reader_pkg::REG_CTRL:   apb_rsp.prdata = {31'd0, cfg.enable};
      ram_reader_pkg::REG_BASE:   apb_rsp.prdata = cfg.base;
      ram_reader_pkg::REG_CFG:    apb_rsp.prdata = {16'd0, cfg.cfg.raw};
      ram_reader_pkg::REG_STATUS: apb_rsp.prdata = {16'd0, slot_index};
      default:                    apb_rsp.prdata = 32'd0;
    endcase
  end

  assign apb_rsp.pready  = 1'b1;  // No wait states.
  assign apb_rsp.pslverr = wr_access & ~wr_mapped;

  a_penable_psel: assert property (@(posedge aclk) disable iff (!aresetn)
    apb_req.penable |-> apb_req.psel);

endmodule

// ==== burst_addr_gen.sv ====
`timescale 1ns/1ns

module burst_addr_gen
(
  input  logic                                   aclk,
  input  logic                                   aresetn,
  input  ram_reader_pkg::reader_cfg_t            cfg,
  input  logic [ram_reader_pkg::FIFO_CNT_W-1:0]  fifo_count,
  input  logic                                   r_valid,
  input  logic                                   r_last,
  output ram_reader_pkg::axi_ar_t                ar,
  output logic                                   ar_valid,
  input  logic                                   ar_ready,
  output logic [ram_reader_pkg::SLOT_W-1:0]      slot_index
);

  logic                                  enable_q;
  logic                                  enable_rise;
  logic                                  in_flight;
  logic                                  ar_done;
  logic                                  room;
  logic                                  issue;
  logic [ram_reader_pkg::SLOT_W-1:0]     limit;
  logic [ram_reader_pkg::SLOT_W-1:0]     quarter_start;
  logic [ram_reader_pkg::SLOT_W-1:0]     issue_index;
  logic [ram_reader_pkg::AXI_ADDR_W-1:0] slot_offset;

  assign enable_rise   = cfg.enable & ~enable_q;
  assign quarter_start = {cfg.cfg.parts.start_quarter, {(ram_reader_pkg::SLOT_W-2){1'b0}}};
  assign ar_done       = ar_valid & ar_ready;

  // ********************
  // Slot stepping.
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      enable_q   <= 1'b0;
      slot_index <= '0;
      limit      <= '0;
    end
    else
    begin
      enable_q <= cfg.enable;
      if (enable_rise)
      begin
        slot_index <= quarter_start;
        limit      <= cfg.cfg.raw;
      end
      else if (ar_done)
      begin
        if (slot_index < limit)
          slot_index <= slot_index + 1'b1;
        else
        begin
          slot_index <= quarter_start;  // Wrap to the quarter start.
          limit      <= cfg.cfg.raw;
        end
      end
    end
  end

  // ********************
  // Address issue.
  assign room  = fifo_count <= (ram_reader_pkg::FIFO_DEPTH - ram_reader_pkg::BURST_BEATS);
  assign issue = cfg.enable & ~in_flight & ~ar_valid & room;

  // The index loads on the same edge as a rise of enable.
  assign issue_index = enable_rise ? quarter_start : slot_index;
  assign slot_offset = {{(ram_reader_pkg::AXI_ADDR_W-ram_reader_pkg::SLOT_W){1'b0}},
                        issue_index} << ram_reader_pkg::SLOT_SHIFT;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      ar_valid  <= 1'b0;
      in_flight <= 1'b0;
    end
    else
    begin
      if (r_valid & r_last)
        in_flight <= 1'b0;  // Burst done.
      if (issue)
      begin
        ar_valid  <= 1'b1;
        in_flight <= 1'b1;
      end
      else if (ar_done)
        ar_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (issue)
      ar.araddr <= cfg.base + slot_offset;
  end

  a_addr_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar.araddr));

  a_single_burst: assert property (@(posedge aclk) disable iff (!aresetn)
    r_valid && r_last |-> in_flight && !ar_valid);

endmodule

// ==== beat_fifo.sv ====
`timescale 1ns/1ns

module beat_fifo
(
  input  logic                                   aclk,
  input  logic                                   aresetn,
  input  logic                                   wr_valid,
  input  logic [ram_reader_pkg::AXI_DATA_W-1:0]  wr_data,
  output logic [ram_reader_pkg::AXI_DATA_W-1:0]  rd_data,
  output logic                                   rd_valid,
  input  logic                                   rd_pop,
  output logic [ram_reader_pkg::FIFO_CNT_W-1:0]  count
);

  logic [ram_reader_pkg::AXI_DATA_W-1:0] mem [ram_reader_pkg::FIFO_DEPTH];
  logic [ram_reader_pkg::FIFO_CNT_W-2:0] wr_ptr;
  logic [ram_reader_pkg::FIFO_CNT_W-2:0] rd_ptr;
  logic                                  full;
  logic                                  wr_en;
  logic                                  rd_en;

  assign full     = count == ram_reader_pkg::FIFO_DEPTH;
  assign rd_valid = count != '0;
  assign wr_en    = wr_valid & ~full;
  assign rd_en    = rd_pop & rd_valid;
  assign rd_data  = mem[rd_ptr];  // Head word, fall-through.

  always_ff @(posedge aclk)
  begin
    if (wr_en)
      mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth.
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
    !(wr_valid && full) && !(rd_pop && !rd_valid));

endmodule

// ==== sample_splitter.sv ====
`timescale 1ns/1ns

module sample_splitter
(
  input  logic                                  aclk,
  input  logic                                  aresetn,
  input  logic [ram_reader_pkg::AXI_DATA_W-1:0] beat,
  input  logic                                  beat_valid,
  output logic                                  beat_pop,
  output logic [ram_reader_pkg::SAMPLE_W-1:0]   tdata,
  output logic                                  tvalid,
  input  logic                                  tready
);

  logic high_half;
  logic sent;

  assign tvalid = beat_valid;
  assign sent   = tvalid & tready;

  // Low half first.
  assign tdata = high_half ? beat[ram_reader_pkg::AXI_DATA_W-1:ram_reader_pkg::SAMPLE_W]
                           : beat[ram_reader_pkg::SAMPLE_W-1:0];

  assign beat_pop = sent & high_half;  // Beat fully sent.

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      high_half <= 1'b0;
    else if (sent)
      high_half <= ~high_half;
  end

endmodule

// ==== ram_reader_top.sv ====
`timescale 1ns/1ns

module ram_reader_top
(
  input  logic                                aclk,
  input  logic                                aresetn,
  input  ram_reader_pkg::apb_req_t            apb_req,
  output ram_reader_pkg::apb_rsp_t            apb_rsp,
  output ram_reader_pkg::axi_ar_t             m_axi_ar,
  output logic                                m_axi_arvalid,
  input  logic                                m_axi_arready,
  input  ram_reader_pkg::axi_r_t              m_axi_r,
  input  logic                                m_axi_rvalid,
  output logic [ram_reader_pkg::SAMPLE_W-1:0] m_axis_tdata,
  output logic                                m_axis_tvalid,
  input  logic                                m_axis_tready
);

  ram_reader_pkg::reader_cfg_t           reader_cfg;
  logic [ram_reader_pkg::SLOT_W-1:0]     slot_index;
  logic [ram_reader_pkg::FIFO_CNT_W-1:0] fifo_count;
  logic [ram_reader_pkg::AXI_DATA_W-1:0] fifo_data;
  logic                                  fifo_valid;
  logic                                  fifo_pop;

  ram_reader_apb_regs regs_0 (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .slot_index (slot_index),
    .cfg        (reader_cfg)
  );

  burst_addr_gen gen_0 (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .cfg        (reader_cfg),
    .fifo_count (fifo_count),
    .r_valid    (m_axi_rvalid),
    .r_last     (m_axi_r.rlast),
    .ar         (m_axi_ar),
    .ar_valid   (m_axi_arvalid),
    .ar_ready   (m_axi_arready),
    .slot_index (slot_index)
  );

  // R beats always accepted.
  beat_fifo fifo_0 (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .wr_valid (m_axi_rvalid),
    .wr_data  (m_axi_r.rdata),
    .rd_data  (fifo_data),
    .rd_valid (fifo_valid),
    .rd_pop   (fifo_pop),
    .count    (fifo_count)
  );

  sample_splitter split_0 (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .beat       (fifo_data),
    .beat_valid (fifo_valid),
    .beat_pop   (fifo_pop),
    .tdata      (m_axis_tdata),
    .tvalid     (m_axis_tvalid),
    .tready     (m_axis_tready)
  );

endmodule

// ==== tb_axi_ram_model.sv ====
`timescale 1ns/1ns

module tb_axi_ram_model
(
  input  logic                    aclk,
  input  logic                    aresetn,
  input  ram_reader_pkg::axi_ar_t ar,
  input  logic                    arvalid,
  output logic                    arready,
  output ram_reader_pkg::axi_r_t  r,
  output logic                    rvalid,
  input  logic [1:0]              delay_bits
);

  localparam logic [31:0] FILL_WORD = 32'h5A5A_0000;

  logic        busy;
  logic [31:0] addr;
  logic [31:0] beat_addr;
  logic [4:0]  beat;
  logic [1:0]  delay;

  assign beat_addr = addr + beat * ram_reader_pkg::BEAT_BYTES;

  initial
  begin
    arready = 1'b0;
    rvalid  = 1'b0;
    r       = '0;
  end

  always @(posedge aclk)
  begin
    if (!aresetn)
    begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      r       <= '0;
      busy    <= 1'b0;
      addr    <= '0;
      beat    <= '0;
      delay   <= '0;
    end
    else
    begin
      rvalid <= 1'b0;
      if (!busy)
      begin
        arready <= 1'b1;
        if (arvalid && arready)
        begin
          busy    <= 1'b1;
          arready <= 1'b0;  // One burst at a time.
          addr    <= ar.araddr;
          beat    <= '0;
          delay   <= delay_bits;
        end
      end
      else if (delay != 2'd0)
        delay <= delay - 2'd1;
      else
      begin
        rvalid  <= 1'b1;
        r.rdata <= {FILL_WORD, beat_addr};
        r.rlast <= beat == ram_reader_pkg::BURST_BEATS - 1;
        beat    <= beat + 5'd1;
        delay   <= delay_bits;
        if (beat == ram_reader_pkg::BURST_BEATS - 1)
          busy <= 1'b0;
      end
    end
  end

endmodule

// ==== tb_ram_reader.sv ====
`timescale 1ns/1ns

module tb_ram_reader;

  localparam logic [31:0] FILL_WORD     = 32'h5A5A_0000;
  localparam int          BURST_SAMPLES = ram_reader_pkg::BURST_BEATS * 2;

  logic                                aclk;
  logic                                aresetn;
  ram_reader_pkg::apb_req_t            apb_req;
  ram_reader_pkg::apb_rsp_t            apb_rsp;
  ram_reader_pkg::axi_ar_t             m_axi_ar;
  logic                                m_axi_arvalid;
  logic                                m_axi_arready;
  ram_reader_pkg::axi_r_t              m_axi_r;
  logic                                m_axi_rvalid;
  logic [ram_reader_pkg::SAMPLE_W-1:0] m_axis_tdata;
  logic                                m_axis_tvalid;
  logic                                m_axis_tready;
  logic [1:0]                          delay_bits;
  logic [15:0]                         lfsr;
  logic                                hold_low;
  logic [31:0]                         run_base;
  ram_reader_pkg::cfg_word_u           run_cfg;
  ram_reader_pkg::axi_ar_t             exp_ar;
  ram_reader_pkg::apb_rsp_t            rsp;
  int                                  ar_count;
  int                                  sample_count;
  int                                  value_errors;
  int                                  timeout_errors;
  int                                  protocol_errors;

  ram_reader_top uut (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp),
    .m_axi_ar      (m_axi_ar),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_r       (m_axi_r),
    .m_axi_rvalid  (m_axi_rvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

  tb_axi_ram_model mem_0 (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .ar         (m_axi_ar),
    .arvalid    (m_axi_arvalid),
    .arready    (m_axi_arready),
    .r          (m_axi_r),
    .rvalid     (m_axi_rvalid),
    .delay_bits (delay_bits)
  );

  initial
  begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // ********************
  // Reference model.
  function automatic logic [ram_reader_pkg::SLOT_W-1:0] ref_slot(
    input ram_reader_pkg::cfg_word_u cfg, input int n);
    logic [ram_reader_pkg::SLOT_W-1:0] start;
    logic [ram_reader_pkg::SLOT_W-1:0] idx;
    start = {cfg.parts.start_quarter, 14'd0};
    idx   = start;
    for (int k = 0; k < n; k++)
      idx = (idx < cfg.raw) ? idx + 16'd1 : start;
    return idx;
  endfunction

  function automatic logic [31:0] ref_addr(input logic [31:0] base,
    input ram_reader_pkg::cfg_word_u cfg, input int n);
    logic [31:0] slot;
    slot = ref_slot(cfg, n);
    return base + (slot << ram_reader_pkg::SLOT_SHIFT);
  endfunction

  function automatic logic [31:0] ref_sample(input logic [31:0] base,
    input ram_reader_pkg::cfg_word_u cfg, input int j);
    int          beat;
    logic [31:0] addr;
    beat = j / 2;
    addr = ref_addr(base, cfg, beat / ram_reader_pkg::BURST_BEATS)
           + (beat % ram_reader_pkg::BURST_BEATS) * ram_reader_pkg::BEAT_BYTES;
    return (j % 2 == 1) ? FILL_WORD : addr;  // Low half first.
  endfunction

  function automatic ram_reader_pkg::apb_rsp_t expect_rsp(input logic [31:0] data,
    input logic err);
    ram_reader_pkg::apb_rsp_t e;
    e.prdata  = data;
    e.pready  = 1'b1;
    e.pslverr = err;
    return e;
  endfunction

  // ********************
  // Compare tasks.
  task automatic compare_addr(input string name, input ram_reader_pkg::axi_ar_t exp,
    input ram_reader_pkg::axi_ar_t act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected %h, actual %h", name, exp.araddr, act.araddr);
      value_errors++;
    end
  endtask

  task automatic compare_sample(input string name,
    input logic [ram_reader_pkg::SAMPLE_W-1:0] exp,
    input logic [ram_reader_pkg::SAMPLE_W-1:0] act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic compare_slot(input string name,
    input logic [ram_reader_pkg::SLOT_W-1:0] exp,
    input logic [ram_reader_pkg::SLOT_W-1:0] act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic compare_rsp(input string name, input ram_reader_pkg::apb_rsp_t exp,
    input ram_reader_pkg::apb_rsp_t act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected %h/%b/%b, actual %h/%b/%b", name,
               exp.prdata, exp.pready, exp.pslverr, act.prdata, act.pready, act.pslverr);
      value_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR: timed out waiting for %s", what);
    timeout_errors++;
  endtask

  // ********************
  // APB master.
  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
    output ram_reader_pkg::apb_rsp_t r);
    @(posedge aclk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge aclk);
    apb_req.penable <= 1'b1;
    @(posedge aclk);
    r        = apb_rsp;
    r.prdata = '0;  // Don't care on writes.
    apb_req <= '0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output ram_reader_pkg::apb_rsp_t r);
    @(posedge aclk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
    @(posedge aclk);
    apb_req.penable <= 1'b1;
    @(posedge aclk);
    r = apb_rsp;
    apb_req <= '0;
  endtask

  task automatic start_run(input logic [31:0] base, input logic [15:0] cfg, input logic hold);
    ram_reader_pkg::apb_rsp_t r;
    run_base     <= base;
    run_cfg      <= cfg;
    ar_count     <= 0;
    sample_count <= 0;
    hold_low     <= hold;
    apb_write(ram_reader_pkg::REG_BASE, base, r);
    compare_rsp("base write", expect_rsp(32'd0, 1'b0), r);
    apb_write(ram_reader_pkg::REG_CFG, {16'd0, cfg}, r);
    compare_rsp("cfg write", expect_rsp(32'd0, 1'b0), r);
    apb_write(ram_reader_pkg::REG_CTRL, 32'd1, r);
    compare_rsp("enable write", expect_rsp(32'd0, 1'b0), r);
  endtask

  task automatic wait_for_bursts(input string name, input int n, input int limit);
    int i;
    for (i = 0; i < limit && ar_count < n; i++)
      @(posedge aclk);
    if (ar_count < n)
      report_timeout({name, " bursts"});
  endtask

  task automatic stop_and_drain(input string name);
    ram_reader_pkg::apb_rsp_t r;
    int                       i;
    int                       held;
    logic                     seen;
    apb_write(ram_reader_pkg::REG_CTRL, 32'd0, r);
    repeat (2) @(posedge aclk);  // Let a last issued AR show.
    for (i = 0; i < 4000 && (m_axi_arvalid || sample_count != ar_count * BURST_SAMPLES); i++)
      @(posedge aclk);
    if (m_axi_arvalid || sample_count != ar_count * BURST_SAMPLES)
      report_timeout({name, " drain"});
    held = ar_count;
    seen = 1'b0;
    for (i = 0; i < 200; i++)
    begin
      @(posedge aclk);
      if (m_axi_arvalid)
        seen = 1'b1;
    end
    if (seen || ar_count != held)
    begin
      $display("ERROR: %s: a read burst was issued after enable was cleared", name);
      protocol_errors++;
    end
    apb_read(ram_reader_pkg::REG_STATUS, r);
    compare_slot({name, " status"}, ref_slot(run_cfg, ar_count),
                 r.prdata[ram_reader_pkg::SLOT_W-1:0]);
  endtask

  // Random tready and memory delays.
  always @(posedge aclk)
  begin
    lfsr = lfsr_next(lfsr);
    m_axis_tready <= hold_low ? 1'b0 : lfsr[0];
    lfsr = lfsr_next(lfsr);
    delay_bits[0] <= lfsr[0];
    lfsr = lfsr_next(lfsr);
    delay_bits[1] <= lfsr[0];
  end

  // Checker for AR addresses and stream samples.
  always @(posedge aclk)
  begin
    if (aresetn)
    begin
      if (m_axi_arvalid && m_axi_arready)
      begin
        exp_ar.araddr = ref_addr(run_base, run_cfg, ar_count);
        compare_addr("ar address", exp_ar, m_axi_ar);
        ar_count <= ar_count + 1;
      end
      if (m_axis_tvalid && m_axis_tready)
      begin
        compare_sample("stream sample", ref_sample(run_base, run_cfg, sample_count),
                       m_axis_tdata);
        sample_count <= sample_count + 1;
      end
    end
  end

  initial
  begin
    aresetn         = 1'b0;
    apb_req         = '0;
    m_axis_tready   = 1'b0;
    delay_bits      = 2'd0;
    lfsr            = 16'd19703;
    hold_low        = 1'b0;
    run_base        = '0;
    run_cfg         = '0;
    ar_count        = 0;
    sample_count    = 0;
    value_errors    = 0;
    timeout_errors  = 0;
    protocol_errors = 0;
    repeat (10) @(posedge aclk);
    aresetn <= 1'b1;
    @(posedge aclk);

    // ********************
    // Reset state and registers.
    if (m_axi_arvalid !== 1'b0 || m_axis_tvalid !== 1'b0)
    begin
      $display("ERROR: arvalid or tvalid is not low after reset");
      protocol_errors++;
    end
    apb_read(ram_reader_pkg::REG_CTRL, rsp);
    compare_rsp("ctrl after reset", expect_rsp(32'd0, 1'b0), rsp);
    apb_read(ram_reader_pkg::REG_BASE, rsp);
    compare_rsp("base after reset", expect_rsp(32'd0, 1'b0), rsp);
    apb_read(ram_reader_pkg::REG_CFG, rsp);
    compare_rsp("cfg after reset", expect_rsp(32'd0, 1'b0), rsp);
    apb_read(ram_reader_pkg::REG_STATUS, rsp);
    compare_rsp("status after reset", expect_rsp(32'd0, 1'b0), rsp);
    apb_write(ram_reader_pkg::REG_STATUS, 32'h0000_00FF, rsp);
    compare_rsp("status write", expect_rsp(32'd0, 1'b1), rsp);
    apb_write(4'h2, 32'h0000_0001, rsp);
    compare_rsp("unmapped write", expect_rsp(32'd0, 1'b1), rsp);
    apb_read(ram_reader_pkg::REG_STATUS, rsp);
    compare_rsp("status after write", expect_rsp(32'd0, 1'b0), rsp);
    apb_write(ram_reader_pkg::REG_BASE, 32'hCAFE_0180, rsp);
    apb_read(ram_reader_pkg::REG_BASE, rsp);
    compare_rsp("base readback", expect_rsp(32'hCAFE_0180, 1'b0), rsp);
    apb_write(ram_reader_pkg::REG_CFG, 32'h0000_4002, rsp);
    apb_read(ram_reader_pkg::REG_CFG, rsp);
    compare_rsp("cfg readback", expect_rsp(32'h0000_4002, 1'b0), rsp);

    // Quarter 1, slots 0x4000 to 0x4002 and wrap.
    start_run(32'h0010_0000, 16'h4002, 1'b0);
    wait_for_bursts("wrap walk", 10, 4000);
    stop_and_drain("wrap walk");

    // Re-enable in quarter 3, limit just past the start.
    start_run(32'h0080_0000, 16'hC001, 1'b0);
    wait_for_bursts("restart", 5, 3000);
    stop_and_drain("restart");

    // ********************
    // Stream stalled, FIFO fills.
    start_run(32'h0200_0000, 16'h0005, 1'b1);
    wait_for_bursts("stalled stream", 4, 2000);
    repeat (200) @(posedge aclk);
    if (ar_count > 4 || m_axis_tvalid !== 1'b1)
    begin
      $display("ERROR: with tready low, %0d bursts went out or no sample is waiting",
               ar_count);
      protocol_errors++;
    end
    compare_sample("stalled head", ref_sample(run_base, run_cfg, 0), m_axis_tdata);
    hold_low <= 1'b0;
    stop_and_drain("stalled stream");

    $display("Errors: %0d value, %0d timeout, %0d protocol", value_errors, timeout_errors,
             protocol_errors);
    if (value_errors + timeout_errors + protocol_errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// ==== ram_reader_top.f ====
ram_reader_pkg.sv
ram_reader_apb_regs.sv
burst_addr_gen.sv
beat_fifo.sv
sample_splitter.sv
ram_reader_top.sv
tb_axi_ram_model.sv
tb_ram_reader.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ram_reader \
  -f ram_reader_top.f -o tb_ram_reader_sim
./obj_dir/tb_ram_reader_sim > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
exit 0
